//--- logic/nes_bus_pkg.sv
package nes_bus_pkg;

    // ------------------------------
    // Console memory map
    // ------------------------------
    localparam int ADDR_W     = 16;        // CPU address bus
    localparam int SRAM_BYTES = 2048;      // Work RAM, 2 KB
    localparam int ROM_BYTES  = 16384;     // Program ROM, 16 KB
    localparam int SRAM_AW    = $clog2(SRAM_BYTES);
    localparam int ROM_AW     = $clog2(ROM_BYTES);
    localparam int PPU_REG_W  = 3;         // Eight PPU registers, mirrored

    // Window bounds
    localparam logic [ADDR_W-1:0] PPU_BASE  = 16'h2000;
    localparam logic [ADDR_W-1:0] PPU_LIMIT = 16'h3FFF;
    localparam logic [ADDR_W-1:0] ROM_BASE  = 16'h8000;

    // 0000-1FFF  work RAM, 2K mirrored four times
    // 2000-3FFF  PPU register window
    // 4000-7FFF  nothing here, reads as zero
    // 8000-FFFF  program ROM, 16K mirrored at C000
    typedef enum logic [1:0] {
        REGION_SRAM,
        REGION_PPU,
        REGION_ROM,
        REGION_NONE
    } bus_region_e;

    // ------------------------------
    // Decoded bus request
    // ------------------------------
    // Leaves the decode stage once per cycle
    // rd and wr never high together
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // CPU or DMA address
        logic [7:0]        wdata;  // Write data from CPU
        logic              rd;     // Live read
        logic              wr;     // Live write, RAM or PPU only
        bus_region_e       region; // Target of addr
    } bus_req_t;

endpackage

//--- logic/nes_link_pkg.sv
package nes_link_pkg;

    // ------------------------------
    // Serial link timing
    // ------------------------------
    localparam int CLKS_PER_BIT = 8;                  // Clocks per serial bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;   // Start bit check point
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    // 8N1 receiver
    typedef enum logic [1:0] {
        RX_IDLE,   // Waiting for falling edge
        RX_START,  // Confirm start bit at mid-bit
        RX_DATA,   // Eight data bits, LSB first
        RX_STOP    // Check stop bit
    } rx_state_e;

    // ROM loader
    typedef enum logic {
        LD_IDLE,
        LD_LOAD
    } ld_state_e;

    // One ROM byte write per received byte
    typedef struct packed {
        logic [nes_bus_pkg::ROM_AW-1:0] addr; // Byte offset in ROM
        logic [7:0]                     data;
        logic                           wr;   // One-cycle strobe
    } rom_wr_t;

endpackage

//--- logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import nes_link_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       serial_rx,
    output logic [7:0] rx_byte,
    output logic       rx_ready
);

    logic             rx_meta;   // First sync flop
    logic             rx_sync;   // Safe to use
    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;   // Clocks within current bit
    logic [2:0]       bit_idx;   // Data bit being shifted in
    logic [7:0]       shift;     // Assembled byte LSB first
    logic             half_pt;   // Middle of start bit
    logic             bit_end;   // Middle of next bit

    // ------------------------------
    // Line synchronizer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;      // Idle line is high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= serial_rx;
            rx_sync <= rx_meta;
        end
    end

    assign half_pt = (clk_cnt == CNT_W'(HALF_BIT - 1));
    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // ------------------------------
    // Bit timing FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            unique case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= RX_START;   // Falling edge seen
                end
                RX_START: begin
                    if (half_pt) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Line back high means a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    clk_cnt <= clk_cnt + 1'b1;     // Wraps at bit end
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_end) state <= RX_IDLE; // Bad stop bit just drops the byte
                end
            endcase
        end
    end

    // Data shifter samples mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shift <= {rx_sync, shift[7:1]};
    end

    assign rx_byte  = shift;
    assign rx_ready = (state == RX_STOP) && bit_end && rx_sync;   // Good stop bit only

    // No strobe while waiting for a start bit
    a_no_ready_idle: assert property (@(posedge clk) disable iff (reset)
        !(rx_ready && state == RX_IDLE));

endmodule

//--- logic/rom_loader.sv
`timescale 1ns/1ps

module rom_loader import nes_bus_pkg::*, nes_link_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_byte,
    input  logic       rx_ready,
    output logic       loading,
    output rom_wr_t    rom_wr
);

    ld_state_e         state;
    logic [ROM_AW-1:0] addr_cnt;   // Next ROM offset
    logic              last_byte;  // Strobe for byte ROM_BYTES

    assign last_byte = (state == LD_LOAD) && (addr_cnt == ROM_AW'(ROM_BYTES - 1));
    assign loading   = (state == LD_LOAD);   // Holds the bus off

    // ------------------------------
    // Load sequencing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= LD_IDLE;
            addr_cnt <= '0;
        end else if (rx_ready) begin
            unique case (state)
                LD_IDLE: begin
                    state    <= LD_LOAD;    // First byte opens a load
                    addr_cnt <= ROM_AW'(1); // Byte 0 goes out now
                end
                LD_LOAD: begin
                    addr_cnt <= addr_cnt + 1'b1;   // Wraps to 0 after last
                    if (last_byte) state <= LD_IDLE;
                end
            endcase
        end
    end

    // Write port trails the strobe by one cycle
    always_ff @(posedge clk) begin
        rom_wr.data <= rx_byte;
        rom_wr.addr <= addr_cnt;   // Zero whenever idle, so a fresh load starts at 0
        if (reset) begin
            rom_wr.wr <= 1'b0;
        end else begin
            rom_wr.wr <= rx_ready;   // One write per received byte
        end
    end

    // Last write trails loading by one cycle
    a_wr_in_load: assert property (@(posedge clk) disable iff (reset)
        rom_wr.wr |-> (loading || $past(loading)));

endmodule

//--- logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import nes_bus_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [7:0]        cpu_wdata,
    input  logic              cpu_rd,
    input  logic              cpu_wr,
    input  logic              dma_active,
    input  logic [ADDR_W-1:0] dma_addr,
    input  logic              loading,
    output bus_req_t          req
);

    logic [ADDR_W-1:0] addr_sel;   // DMA steals the bus
    bus_region_e       region;
    logic              rd_ok;
    logic              wr_ok;

    assign addr_sel = dma_active ? dma_addr : cpu_addr;

    // ------------------------------
    // Region decode
    // ------------------------------
    always_comb begin
        if (addr_sel < PPU_BASE) begin
            region = REGION_SRAM;      // 0000-1FFF
        end else if (addr_sel <= PPU_LIMIT) begin
            region = REGION_PPU;       // 2000-3FFF
        end else if (addr_sel >= ROM_BASE) begin
            region = REGION_ROM;       // 8000-FFFF
        end else begin
            region = REGION_NONE;      // Expansion area, not fitted
        end
    end

    // Nothing gets through while ROM is loading
    assign rd_ok = cpu_rd && !loading;

    // Read wins if both are asserted
    // DMA is read only, ROM and holes are not writable
    assign wr_ok = cpu_wr && !cpu_rd && !loading && !dma_active &&
                   (region == REGION_SRAM || region == REGION_PPU);

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clk) begin
        req.addr   <= addr_sel;
        req.wdata  <= cpu_wdata;
        req.region <= region;
        if (reset) begin
            req.rd <= 1'b0;
            req.wr <= 1'b0;
        end else begin
            req.rd <= rd_ok;
            req.wr <= wr_ok;
        end
    end

    // ROM stays read only and DMA cycles never write
    a_no_rom_wr: assert property (@(posedge clk) disable iff (reset)
        req.wr |-> (req.region != REGION_ROM) && !$past(dma_active));

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import nes_bus_pkg::*, nes_link_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_req_t             req,
    input  rom_wr_t              rom_wr,
    input  logic [7:0]           ppu_rdata,
    output logic [7:0]           rdata,
    output logic                 rdata_valid,
    output logic                 ppu_rd,
    output logic                 ppu_wr,
    output logic [PPU_REG_W-1:0] ppu_reg,
    output logic [7:0]           ppu_wdata
);

    logic [7:0] sram [SRAM_BYTES];   // Work RAM
    logic [7:0] rom  [ROM_BYTES];    // Program ROM, loader fills it

    logic [SRAM_AW-1:0] sram_idx;    // Low bits only, so 2K mirrors
    logic [ROM_AW-1:0]  rom_idx;     // C000 lands on 8000
    logic [7:0]         rd_mux;
    logic               ppu_hit;

    assign sram_idx = req.addr[SRAM_AW-1:0];
    assign rom_idx  = req.addr[ROM_AW-1:0];
    assign ppu_hit  = (req.region == REGION_PPU);

    // ------------------------------
    // Memory arrays
    // ------------------------------
    always_ff @(posedge clk) begin
        if (req.wr && req.region == REGION_SRAM) begin
            sram[sram_idx] <= req.wdata;
        end
    end

    // Loader port, the bus never writes here
    always_ff @(posedge clk) begin
        if (rom_wr.wr) begin
            rom[rom_wr.addr] <= rom_wr.data;
        end
    end

    // Read data select
    always_comb begin
        unique case (req.region)
            REGION_SRAM: rd_mux = sram[sram_idx];
            REGION_PPU:  rd_mux = ppu_rdata;    // Straight from the PPU
            REGION_ROM:  rd_mux = rom[rom_idx];
            REGION_NONE: rd_mux = 8'h00;        // Open space reads zero
        endcase
    end

    // ------------------------------
    // Output registers
    // ------------------------------
    always_ff @(posedge clk) begin
        rdata     <= rd_mux;
        ppu_reg   <= req.addr[PPU_REG_W-1:0];   // 2000-2007 mirrored across window
        ppu_wdata <= req.wdata;
        if (reset) begin
            rdata_valid <= 1'b0;
            ppu_rd      <= 1'b0;
            ppu_wr      <= 1'b0;
        end else begin
            rdata_valid <= req.rd;
            ppu_rd      <= req.rd && ppu_hit;   // One-cycle strobes
            ppu_wr      <= req.wr && ppu_hit;
        end
    end

    // Decoder must never issue read and write together
    a_ppu_excl: assert property (@(posedge clk) disable iff (reset)
        !(ppu_rd && ppu_wr));

endmodule

//--- logic/nes_memory_bus.sv
`timescale 1ns/1ps

module nes_memory_bus import nes_bus_pkg::*, nes_link_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 serial_rx,
    input  logic [ADDR_W-1:0]    cpu_addr,
    input  logic [7:0]           cpu_wdata,
    input  logic                 cpu_rd,
    input  logic                 cpu_wr,
    input  logic                 dma_active,
    input  logic [ADDR_W-1:0]    dma_addr,
    input  logic [7:0]           ppu_rdata,
    output logic [7:0]           rdata,
    output logic                 rdata_valid,
    output logic                 ppu_rd,
    output logic                 ppu_wr,
    output logic [PPU_REG_W-1:0] ppu_reg,
    output logic [7:0]           ppu_wdata,
    output logic                 loading
);

    logic [7:0] rx_byte;
    logic       rx_ready;
    rom_wr_t    rom_wr;
    bus_req_t   req;

    // ------------------------------
    // Serial load path
    // ------------------------------
    uart_rx u_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .serial_rx(serial_rx),
        .rx_byte  (rx_byte),
        .rx_ready (rx_ready)
    );

    rom_loader u_rom_loader (
        .clk     (clk),
        .reset   (reset),
        .rx_byte (rx_byte),
        .rx_ready(rx_ready),
        .loading (loading),
        .rom_wr  (rom_wr)
    );

    // ------------------------------
    // Bus pipeline
    // ------------------------------
    bus_decoder u_bus_decoder (
        .clk       (clk),
        .reset     (reset),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rd    (cpu_rd),
        .cpu_wr    (cpu_wr),
        .dma_active(dma_active),
        .dma_addr  (dma_addr),
        .loading   (loading),     // Bus locked out during load
        .req       (req)
    );

    memory_stage u_memory_stage (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .rom_wr     (rom_wr),
        .ppu_rdata  (ppu_rdata),
        .rdata      (rdata),
        .rdata_valid(rdata_valid),
        .ppu_rd     (ppu_rd),
        .ppu_wr     (ppu_wr),
        .ppu_reg    (ppu_reg),
        .ppu_wdata  (ppu_wdata)
    );

endmodule

//--- verif/nes_memory_bus_tb.sv
`timescale 1ns/1ps

module nes_memory_bus_tb import nes_bus_pkg::*, nes_link_pkg::*;;

    // Expected response following a request down the pipe
    typedef struct packed {
        logic       rd_live;   // rdata_valid expected
        logic [7:0] data;
        logic       ppu_rd;
        logic       ppu_wr;
        logic [2:0] preg;
        logic [7:0] wdata;
        logic [2:0] test_id;
    } exp_t;

    localparam longint LOAD_NS   = longint'(ROM_BYTES) * 10 * CLKS_PER_BIT * 8;
    localparam longint MARGIN_NS = 400_000;   // Bus tests are a few thousand cycles

    logic clk = 1'b0;
    logic reset, serial_rx, cpu_rd, cpu_wr, dma_active;
    logic [15:0] cpu_addr, dma_addr;
    logic [7:0]  cpu_wdata, ppu_rdata, rdata, ppu_wdata;
    logic        rdata_valid, ppu_rd, ppu_wr, loading;
    logic [2:0]  ppu_reg;

    exp_t       exp_now, exp_d1, exp_d2;
    logic [7:0] shadow [SRAM_BYTES];   // Work RAM reference
    logic [2:0] cur_test;
    int         bytes_sent;

    always #4 clk = ~clk;   // 8 ns period

    nes_memory_bus u_nes_memory_bus (
        .clk(clk), .reset(reset), .serial_rx(serial_rx),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
        .dma_active(dma_active), .dma_addr(dma_addr), .ppu_rdata(ppu_rdata),
        .rdata(rdata), .rdata_valid(rdata_valid), .ppu_rd(ppu_rd), .ppu_wr(ppu_wr),
        .ppu_reg(ppu_reg), .ppu_wdata(ppu_wdata), .loading(loading)
    );

    // Two-cycle delay to line up with the DUT outputs
    always_ff @(posedge clk) begin
        if (reset) begin
            exp_d1 <= '0;
            exp_d2 <= '0;
        end else begin
            exp_d1 <= exp_now;
            exp_d2 <= exp_d1;
        end
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "rom_load";
            3'd2:    return "rom_read";
            3'd3:    return "ram_rw";
            3'd4:    return "unmapped";
            3'd5:    return "ppu_window";
            default: return "dma";
        endcase
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input int expv, input int actv);
        stop_with_failure($sformatf("[FAIL] %s %s expected %0h actual %0h",
                                    test, what, expv, actv));
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    a_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !loading && !rdata_valid && !ppu_rd && !ppu_wr)
        else stop_with_failure("outputs not idle right after reset");

    a_valid: assert property (@(posedge clk) disable iff (reset)
        rdata_valid == exp_d2.rd_live)
        else report_mismatch(test_label($sampled(exp_d2.test_id)), "rdata_valid",
                             int'($sampled(exp_d2.rd_live)), int'($sampled(rdata_valid)));

    a_rdata: assert property (@(posedge clk) disable iff (reset)
        rdata_valid |-> (rdata == exp_d2.data))
        else report_mismatch(test_label($sampled(exp_d2.test_id)), "rdata",
                             int'($sampled(exp_d2.data)), int'($sampled(rdata)));

    a_ppu_rd: assert property (@(posedge clk) disable iff (reset)
        ppu_rd == exp_d2.ppu_rd)
        else report_mismatch(test_label($sampled(exp_d2.test_id)), "ppu_rd",
                             int'($sampled(exp_d2.ppu_rd)), int'($sampled(ppu_rd)));

    a_ppu_wr: assert property (@(posedge clk) disable iff (reset)
        ppu_wr == exp_d2.ppu_wr)
        else report_mismatch(test_label($sampled(exp_d2.test_id)), "ppu_wr",
                             int'($sampled(exp_d2.ppu_wr)), int'($sampled(ppu_wr)));

    a_ppu_reg: assert property (@(posedge clk) disable iff (reset)
        (ppu_rd || ppu_wr) |-> (ppu_reg == exp_d2.preg))
        else report_mismatch(test_label($sampled(exp_d2.test_id)), "ppu_reg",
                             int'($sampled(exp_d2.preg)), int'($sampled(ppu_reg)));

    a_ppu_wdata: assert property (@(posedge clk) disable iff (reset)
        ppu_wr |-> (ppu_wdata == exp_d2.wdata))
        else report_mismatch(test_label($sampled(exp_d2.test_id)), "ppu_wdata",
                             int'($sampled(exp_d2.wdata)), int'($sampled(ppu_wdata)));

    // Loading level against bytes already sent
    a_load_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(loading) |-> (bytes_sent == 0))
        else report_mismatch("rom_load", "bytes at rise", 0, $sampled(bytes_sent));

    a_load_hold: assert property (@(posedge clk) disable iff (reset)
        (bytes_sent >= 1 && bytes_sent < ROM_BYTES - 1) |-> loading)
        else report_mismatch("rom_load", "loading", 1, 0);

    a_load_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(loading) |-> (bytes_sent == ROM_BYTES - 1))
        else report_mismatch("rom_load", "bytes at fall", ROM_BYTES - 1,
                             $sampled(bytes_sent));

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [7:0] image_byte(input int a);
        return 8'(a * 7 + 3);   // Low byte of 7A + 3
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] a);
        if (a < 16'h2000) return shadow[a[10:0]];              // 2K mirror
        if (a < 16'h4000) return ppu_rdata;
        if (a >= 16'h8000) return image_byte(int'(a[13:0]));   // 16K mirror
        return 8'h00;
    endfunction

    // ------------------------------
    // Stimulus tasks start at a falling edge
    // ------------------------------
    task automatic send_byte(input logic [7:0] b);
        serial_rx = 1'b0;   // Start bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            serial_rx = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        serial_rx = 1'b1;   // Stop bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        bytes_sent++;
    endtask

    task automatic issue_read(input logic [15:0] addr, input logic live);
        logic [15:0] eff;
        eff = dma_active ? dma_addr : addr;
        cpu_addr = addr;
        cpu_rd   = 1'b1;
        cpu_wr   = 1'b0;
        exp_now  = '0;
        exp_now.rd_live = live;
        exp_now.data    = ref_read(eff);
        exp_now.ppu_rd  = live && (eff >= 16'h2000) && (eff <= 16'h3FFF);
        exp_now.preg    = eff[2:0];
        exp_now.test_id = cur_test;
        @(negedge clk);
    endtask

    task automatic issue_write(input logic [15:0] addr, input logic [7:0] data);
        logic [15:0] eff;
        eff = dma_active ? dma_addr : addr;
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_rd    = 1'b0;
        cpu_wr    = 1'b1;
        exp_now   = '0;
        exp_now.test_id = cur_test;
        if (!dma_active) begin                  // DMA cycles are read only
            if (eff < 16'h2000) shadow[eff[10:0]] = data;
            exp_now.ppu_wr = (eff >= 16'h2000) && (eff <= 16'h3FFF);
            exp_now.preg   = eff[2:0];
            exp_now.wdata  = data;
        end
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        cpu_rd  = 1'b0;
        cpu_wr  = 1'b0;
        exp_now = '0;
        exp_now.test_id = cur_test;
        @(negedge clk);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [15:0] a;
        logic [7:0]  d;
        void'($urandom(34867));
        reset = 1'b1;
        serial_rx = 1'b1;
        cpu_addr = 16'h8000;   // Read held through reset gets no response
        cpu_wdata = '0;
        cpu_rd = 1'b1;
        cpu_wr = 1'b0;
        dma_active = 1'b0;
        dma_addr = '0;
        ppu_rdata = '0;
        exp_now = '0;
        cur_test = 3'd0;
        bytes_sent = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        idle_cycle();
        idle_cycle();

        cur_test = 3'd1;
        fork
            for (int i = 0; i < ROM_BYTES; i++) send_byte(image_byte(i));
            begin
                wait (bytes_sent >= 2);
                for (int i = 0; i < 16; i++) issue_read(16'($urandom_range(16'hFFFF, 0)), 1'b0);
                idle_cycle();
            end
        join
        assert (!loading) else stop_with_failure("loading still high after the last ROM byte");
        idle_cycle();

        cur_test = 3'd2;
        issue_read(16'h8123, 1'b1);
        issue_read(16'hC123, 1'b1);   // Same byte through the mirror
        for (int i = 0; i < 200; i++) issue_read(16'($urandom_range(16'hFFFF, 16'h8000)), 1'b1);
        issue_write(16'hA456, ~image_byte(int'(14'h2456)));   // Dropped
        issue_read(16'hA456, 1'b1);
        issue_read(16'hE456, 1'b1);

        cur_test = 3'd3;
        for (int i = 0; i < SRAM_BYTES; i++) begin   // Fill every cell through a random mirror
            issue_write(16'(i) | (16'($urandom_range(3, 0)) << 11), 8'($urandom));
        end
        for (int i = 0; i < 400; i++) begin
            a = 16'($urandom_range(16'h1FFF, 0));
            d = 8'($urandom);
            case ($urandom_range(2, 0))
                0: issue_write(a, d);
                1: issue_read(a, 1'b1);
                default: begin
                    issue_write(a, d);
                    issue_read(a ^ 16'h0800, 1'b1);   // Same cell next cycle via other mirror
                end
            endcase
        end

        cur_test = 3'd4;
        for (int i = 0; i < 30; i++) issue_read(16'($urandom_range(16'h7FFF, 16'h4000)), 1'b1);
        issue_write(16'h5000, 8'hA5);
        issue_read(16'h5000, 1'b1);

        cur_test = 3'd5;
        for (int i = 0; i < 50; i++) begin
            ppu_rdata = 8'($urandom);   // Held through the memory stage cycle
            issue_read(16'($urandom_range(16'h3FFF, 16'h2000)), 1'b1);
            issue_write(16'($urandom_range(16'h3FFF, 16'h2000)), 8'($urandom));
        end
        idle_cycle();

        cur_test = 3'd6;
        dma_active = 1'b1;
        for (int i = 0; i < 60; i++) begin
            a = ($urandom_range(1, 0) == 0) ? 16'($urandom_range(16'h1FFF, 0))
                                            : 16'($urandom_range(16'hFFFF, 16'h8000));
            dma_addr = a;
            if (a < 16'h2000 && i % 3 == 0) issue_write(16'h0100, 8'($urandom));
            issue_read(16'($urandom_range(16'h7FFF, 16'h4000)), 1'b1);
        end
        dma_active = 1'b0;
        for (int i = 0; i < 40; i++) issue_read(16'($urandom_range(16'h1FFF, 0)), 1'b1);
        idle_cycle();
        idle_cycle();
        idle_cycle();

        $display("PASS: all tests");
        $finish;
    end

    // Watchdog covers the full serial load and the bus tests
    initial begin
        #(LOAD_NS + MARGIN_NS);
        stop_with_failure("watchdog timeout, the tests did not finish in time");
    end

endmodule

//--- project.f
logic/nes_bus_pkg.sv
logic/nes_link_pkg.sv
logic/uart_rx.sv
logic/rom_loader.sv
logic/bus_decoder.sv
logic/memory_stage.sv
logic/nes_memory_bus.sv
verif/nes_memory_bus_tb.sv

//--- Makefile
# Verilator build and run for the NES memory bus testbench

SIM      = verilator
TOP      = nes_memory_bus_tb
FILELIST = project.f
FLAGS    = --binary --timing --assert -j 0
PASS_MSG = PASS: all tests

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) -o V$(TOP)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
